// File: dv/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

	localparam int PROG_LEN     = 64;
	localparam int HALF_PERIOD  = 50;
	localparam int DRIVE_DLY    = 1;
	localparam int RUN_TIMEOUT  = 200;
	localparam int DRAIN_CYCLES = 10;

	logic                           clk = 1'b0;
	logic                           rst;
	logic [cpu_pkg::XLEN-1:0]       i_inst;
	logic [cpu_pkg::XLEN-1:0]       o_pc;
	logic                           o_wb_we;
	logic [cpu_pkg::REG_ADDR_W-1:0] o_wb_addr;
	logic [cpu_pkg::XLEN-1:0]       o_wb_data;

	logic [31:0] prog [PROG_LEN];
	logic [31:0] model_regs [0:31];
	logic [31:0] lfsr_state;
	logic [31:0] exp_pc [$];
	logic [4:0]  exp_addr [$];
	logic [31:0] exp_data [$];
	int          wb_idx;
	int          cycle;

	cpu_core uut (
		.i_clk(clk), .i_rst(rst), .i_inst(i_inst), .o_pc(o_pc),
		.o_wb_we(o_wb_we), .o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data)
	);

	initial begin
		forever #HALF_PERIOD clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [2:0] pick_logic_f3(input logic [1:0] sub);
		logic [2:0] f3;
		if (sub == 2'd0) begin
			f3 = cpu_pkg::FUNCT3_XOR;
		end else if (sub == 2'd1) begin
			f3 = cpu_pkg::FUNCT3_OR;
		end else begin
			f3 = cpu_pkg::FUNCT3_AND;
		end
		return f3;
	endfunction

	// Registers x0 to x7 only, so hazards are dense.
	function automatic logic [31:0] random_inst();
		logic [2:0]  kind;
		logic [1:0]  sub;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [31:0] inst;
		kind = 3'(take_bits(3));
		sub  = 2'(take_bits(2));
		rd   = 5'(take_bits(3));
		rs1  = 5'(take_bits(3));
		rs2  = 5'(take_bits(3));
		imm  = 12'(take_bits(12));
		case (kind)
			3'd0: begin
				// Encodings outside the subset.
				case (sub)
					2'd0: inst = encode(imm[11:5], imm[4:0], rs1, 3'b010, rd, 7'b0000011);
					2'd1: inst = encode(imm[11:5], imm[4:0], rs1, 3'b000, rd, cpu_pkg::OPC_OP_IMM);
					2'd2: inst = encode(7'd0, rs2, rs1, cpu_pkg::FUNCT3_SLL, rd, cpu_pkg::OPC_OP);
					default: inst = encode(7'b0100001, imm[4:0], rs1, cpu_pkg::FUNCT3_SRL_SRA, rd,
						cpu_pkg::OPC_OP_IMM);
				endcase
			end
			3'd1, 3'd2: begin
				inst = encode(imm[11:5], imm[4:0], rs1, pick_logic_f3(sub), rd,
					cpu_pkg::OPC_OP_IMM);
			end
			3'd3, 3'd4: begin
				if (sub == 2'd0) begin
					inst = encode(7'd0, imm[4:0], rs1, cpu_pkg::FUNCT3_SLL, rd,
						cpu_pkg::OPC_OP_IMM);
				end else if (sub == 2'd1) begin
					inst = encode(cpu_pkg::FUNCT7_SRL, imm[4:0], rs1, cpu_pkg::FUNCT3_SRL_SRA, rd,
						cpu_pkg::OPC_OP_IMM);
				end else begin
					inst = encode(cpu_pkg::FUNCT7_SRA, imm[4:0], rs1, cpu_pkg::FUNCT3_SRL_SRA, rd,
						cpu_pkg::OPC_OP_IMM);
				end
			end
			default: begin
				inst = encode(7'd0, rs2, rs1, pick_logic_f3(sub), rd, cpu_pkg::OPC_OP);
			end
		endcase
		return inst;
	endfunction

	// In-order ISA model. Returns 1 when the instruction writes a register.
	function automatic logic ref_exec(input logic [31:0] inst, output logic [4:0] rd,
		output logic [31:0] res);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		logic        valid;
		opc   = inst[6:0];
		f3    = inst[14:12];
		f7    = inst[31:25];
		sh    = inst[24:20];
		rd    = inst[11:7];
		a     = model_regs[inst[19:15]];
		valid = 1'b1;
		res   = '0;
		if (opc == cpu_pkg::OPC_OP_IMM) begin
			b = {20'h0, inst[31:20]}; // Zero-extended immediate.
			case (f3)
				cpu_pkg::FUNCT3_XOR: res = a ^ b;
				cpu_pkg::FUNCT3_OR:  res = a | b;
				cpu_pkg::FUNCT3_AND: res = a & b;
				cpu_pkg::FUNCT3_SLL: res = a << sh;
				cpu_pkg::FUNCT3_SRL_SRA: begin
					if (f7 == cpu_pkg::FUNCT7_SRL) begin
						res = a >> sh;
					end else if (f7 == cpu_pkg::FUNCT7_SRA) begin
						res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
					end else begin
						valid = 1'b0;
					end
				end
				default: valid = 1'b0;
			endcase
		end else if (opc == cpu_pkg::OPC_OP) begin
			b = model_regs[inst[24:20]];
			case (f3)
				cpu_pkg::FUNCT3_XOR: res = a ^ b;
				cpu_pkg::FUNCT3_OR:  res = a | b;
				cpu_pkg::FUNCT3_AND: res = a & b;
				default:             valid = 1'b0;
			endcase
		end else begin
			valid = 1'b0;
		end
		return valid && (rd != 5'd0);
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] pc);
		logic [31:0] word;
		if ((pc >> 2) < PROG_LEN) begin
			word = prog[6'(pc >> 2)];
		end else begin
			word = cpu_pkg::NOP_INST; // Past the end of the program.
		end
		return word;
	endfunction

	// Program memory read just after the rising edge.
	always @(posedge clk) begin
		#DRIVE_DLY;
		i_inst = fetch_word(o_pc);
	end

	// Writeback checker samples at the falling edge.
	always @(negedge clk) begin
		if (rst) begin
			check_value("o_pc in reset", o_pc, 32'h0);
			check_value("o_wb_we in reset", 32'(o_wb_we), 32'h0);
		end else begin
			check_value("o_pc", o_pc, 32'(cycle * 4));
			if (o_wb_we) begin
				if (wb_idx >= exp_data.size()) begin
					abort_run($sformatf("Unexpected writeback to x%0d at cycle %0d",
						o_wb_addr, cycle));
				end else begin
					// Fetched at cycle F and retired at F+4.
					check_value("retire cycle", 32'(cycle), (exp_pc[wb_idx] >> 2) + 32'd4);
					check_value("o_wb_addr", 32'(o_wb_addr), 32'(exp_addr[wb_idx]));
					check_value("o_wb_data", o_wb_data, exp_data[wb_idx]);
					wb_idx++;
				end
			end
			cycle++;
		end
	end

	initial begin
		int          wait_cycles;
		logic [4:0]  rd;
		logic [31:0] res;
		rst        = 1'b1;
		i_inst     = cpu_pkg::NOP_INST;
		wb_idx     = 0;
		cycle      = 0;
		lfsr_state = 32'hb7d9;
		for (int r = 0; r < 32; r++) begin
			model_regs[5'(r)] = '0;
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[6'(i)] = random_inst();
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			if (ref_exec(prog[6'(i)], rd, res)) begin
				exp_pc.push_back(32'(i * 4));
				exp_addr.push_back(rd);
				exp_data.push_back(res);
				model_regs[rd] = res;
			end
		end
		$display("Program has %0d register writes", exp_data.size());

		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		wait_cycles = 0;
		while (wb_idx < exp_data.size()) begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > RUN_TIMEOUT) begin
				abort_run($sformatf("Timeout with %0d of %0d writebacks seen", wb_idx,
					exp_data.size()));
			end
		end
		// Trailing bubbles must not write.
		repeat (DRAIN_CYCLES) @(posedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

// File: list.f
verilog/cpu_pkg.sv
verilog/pc_fetch.sv
verilog/reg_file.sv
verilog/stage_id.sv
verilog/exec_pipe.sv
verilog/cpu_core.sv
dv/tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_cpu -Mdir obj_dir -o tb_cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
	input  logic                           i_clk,
	input  logic                           i_rst,
	input  logic [cpu_pkg::XLEN-1:0]       i_inst,
	output logic [cpu_pkg::XLEN-1:0]       o_pc,
	output logic                           o_wb_we,
	output logic [cpu_pkg::REG_ADDR_W-1:0] o_wb_addr,
	output logic [cpu_pkg::XLEN-1:0]       o_wb_data
);

	logic [cpu_pkg::XLEN-1:0]       id_inst;
	logic                           re1, re2;
	logic [cpu_pkg::REG_ADDR_W-1:0] raddr1, raddr2;
	logic [cpu_pkg::XLEN-1:0]       rdata1, rdata2;
	cpu_pkg::alu_op_e               aluop;
	cpu_pkg::alu_sel_e              alusel;
	logic [cpu_pkg::XLEN-1:0]       opv1, opv2;
	logic [cpu_pkg::REG_ADDR_W-1:0] waddr;
	logic                           we;
	logic                           ex_we, mem_we;
	logic [cpu_pkg::REG_ADDR_W-1:0] ex_waddr, mem_waddr;
	logic [cpu_pkg::XLEN-1:0]       ex_wdata, mem_wdata;

	pc_fetch u_fetch (.i_clk(i_clk), .i_rst(i_rst), .i_inst(i_inst), .o_pc(o_pc), .o_inst(id_inst));

	stage_id u_id (
		.i_inst(id_inst), .i_rdata1(rdata1), .i_rdata2(rdata2),
		.i_ex_we(ex_we), .i_ex_waddr(ex_waddr), .i_ex_wdata(ex_wdata),
		.i_mem_we(mem_we), .i_mem_waddr(mem_waddr), .i_mem_wdata(mem_wdata),
		.o_re1(re1), .o_re2(re2), .o_raddr1(raddr1), .o_raddr2(raddr2),
		.o_aluop(aluop), .o_alusel(alusel), .o_opv1(opv1), .o_opv2(opv2),
		.o_waddr(waddr), .o_we(we)
	);

	// Write port is the MEM/WB register.
	reg_file u_rf (
		.i_clk(i_clk), .i_rst(i_rst), .i_re1(re1), .i_re2(re2),
		.i_raddr1(raddr1), .i_raddr2(raddr2),
		.i_we(o_wb_we), .i_waddr(o_wb_addr), .i_wdata(o_wb_data),
		.o_rdata1(rdata1), .o_rdata2(rdata2)
	);

	exec_pipe u_exec (
		.i_clk(i_clk), .i_rst(i_rst), .i_aluop(aluop), .i_alusel(alusel),
		.i_opv1(opv1), .i_opv2(opv2), .i_waddr(waddr), .i_we(we),
		.o_ex_we(ex_we), .o_ex_waddr(ex_waddr), .o_ex_wdata(ex_wdata),
		.o_mem_we(mem_we), .o_mem_waddr(mem_waddr), .o_mem_wdata(mem_wdata),
		.o_wb_we(o_wb_we), .o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data)
	);

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// All-zero word, opcode 0 is not in the subset.
	localparam logic [XLEN-1:0] NOP_INST = '0;

	// Major opcodes.
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	localparam logic [2:0] FUNCT3_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_AND     = 3'b111;
	localparam logic [2:0] FUNCT3_SLL     = 3'b001;
	localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;

	localparam logic [6:0] FUNCT7_SRL = 7'b0000000;
	localparam logic [6:0] FUNCT7_SRA = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_NOP = 3'd0,
		ALU_AND = 3'd1,
		ALU_OR  = 3'd2,
		ALU_XOR = 3'd3,
		ALU_SLL = 3'd4,
		ALU_SRL = 3'd5,
		ALU_SRA = 3'd6
	} alu_op_e;

	// Result class picks the ALU output group.
	typedef enum logic [1:0] {
		SEL_NOP   = 2'd0,
		SEL_LOGIC = 2'd1,
		SEL_SHIFT = 2'd2
	} alu_sel_e;

endpackage

// File: verilog/exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe (
	input  logic                           i_clk,
	input  logic                           i_rst,
	input  cpu_pkg::alu_op_e               i_aluop,
	input  cpu_pkg::alu_sel_e              i_alusel,
	input  logic [cpu_pkg::XLEN-1:0]       i_opv1,
	input  logic [cpu_pkg::XLEN-1:0]       i_opv2,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_waddr,
	input  logic                           i_we,
	output logic                           o_ex_we,
	output logic [cpu_pkg::REG_ADDR_W-1:0] o_ex_waddr,
	output logic [cpu_pkg::XLEN-1:0]       o_ex_wdata,
	output logic                           o_mem_we,
	output logic [cpu_pkg::REG_ADDR_W-1:0] o_mem_waddr,
	output logic [cpu_pkg::XLEN-1:0]       o_mem_wdata,
	output logic                           o_wb_we,
	output logic [cpu_pkg::REG_ADDR_W-1:0] o_wb_addr,
	output logic [cpu_pkg::XLEN-1:0]       o_wb_data
);

	cpu_pkg::alu_op_e         ex_aluop;
	cpu_pkg::alu_sel_e        ex_alusel;
	logic [cpu_pkg::XLEN-1:0] ex_opv1;
	logic [cpu_pkg::XLEN-1:0] ex_opv2;
	logic [cpu_pkg::XLEN-1:0] logic_res;
	logic [cpu_pkg::XLEN-1:0] shift_res;
	logic [4:0]               shamt;

	// ID/EX register.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_ex_we   <= 1'b0;
			ex_aluop  <= cpu_pkg::ALU_NOP;
			ex_alusel <= cpu_pkg::SEL_NOP;
		end else begin
			o_ex_we   <= i_we;
			ex_aluop  <= i_aluop;
			ex_alusel <= i_alusel;
		end
	end

	always_ff @(posedge i_clk) begin
		ex_opv1    <= i_opv1;
		ex_opv2    <= i_opv2;
		o_ex_waddr <= i_waddr;
	end

	assign shamt = ex_opv2[4:0];

	always_comb begin
		case (ex_aluop)
			cpu_pkg::ALU_AND: logic_res = ex_opv1 & ex_opv2;
			cpu_pkg::ALU_OR:  logic_res = ex_opv1 | ex_opv2;
			cpu_pkg::ALU_XOR: logic_res = ex_opv1 ^ ex_opv2;
			default:          logic_res = '0;
		endcase
		case (ex_aluop)
			cpu_pkg::ALU_SLL: shift_res = ex_opv1 << shamt;
			cpu_pkg::ALU_SRL: shift_res = ex_opv1 >> shamt;
			cpu_pkg::ALU_SRA: shift_res = $signed(ex_opv1) >>> shamt; // Sign fill.
			default:          shift_res = '0;
		endcase
		case (ex_alusel)
			cpu_pkg::SEL_LOGIC: o_ex_wdata = logic_res;
			cpu_pkg::SEL_SHIFT: o_ex_wdata = shift_res;
			default:            o_ex_wdata = '0;
		endcase
	end

	// EX/MEM and MEM/WB control.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_mem_we <= 1'b0;
			o_wb_we  <= 1'b0;
		end else begin
			o_mem_we <= o_ex_we;
			o_wb_we  <= o_mem_we;
		end
	end

	always_ff @(posedge i_clk) begin
		o_mem_waddr <= o_ex_waddr;
		o_mem_wdata <= o_ex_wdata;
		o_wb_addr   <= o_mem_waddr;
		o_wb_data   <= o_mem_wdata;
	end

endmodule

// File: verilog/pc_fetch.sv
`timescale 1ns/1ps

module pc_fetch (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic [cpu_pkg::XLEN-1:0] i_inst,
	output logic [cpu_pkg::XLEN-1:0] o_pc,
	output logic [cpu_pkg::XLEN-1:0] o_inst
);

	// Program counter, one word per cycle.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_pc <= '0;
		end else begin
			o_pc <= o_pc + 32'd4;
		end
	end

	// IF/ID register.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_inst <= cpu_pkg::NOP_INST; // Bubble after reset.
		end else begin
			o_inst <= i_inst;
		end
	end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                           i_clk,
	input  logic                           i_rst,
	input  logic                           i_re1,
	input  logic                           i_re2,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_raddr1,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_raddr2,
	input  logic                           i_we,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_waddr,
	input  logic [cpu_pkg::XLEN-1:0]       i_wdata,
	output logic [cpu_pkg::XLEN-1:0]       o_rdata1,
	output logic [cpu_pkg::XLEN-1:0]       o_rdata2
);

	logic [cpu_pkg::XLEN-1:0] regs [0:31];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[5'(i)] <= '0;
			end
		end else if (i_we) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// Write-first read of one port.
	function automatic logic [cpu_pkg::XLEN-1:0] read_port(
		input logic                           re,
		input logic [cpu_pkg::REG_ADDR_W-1:0] addr
	);
		logic [cpu_pkg::XLEN-1:0] val;
		if (!re) begin
			val = '0;
		end else if (i_we && (i_waddr == addr)) begin
			val = i_wdata; // Writeback bypass.
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		o_rdata1 = read_port(i_re1, i_raddr1);
		o_rdata2 = read_port(i_re2, i_raddr2);
	end

endmodule

// File: verilog/stage_id.sv
`timescale 1ns/1ps

module stage_id (
	input  logic [cpu_pkg::XLEN-1:0]       i_inst,
	input  logic [cpu_pkg::XLEN-1:0]       i_rdata1,
	input  logic [cpu_pkg::XLEN-1:0]       i_rdata2,
	input  logic                           i_ex_we,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_ex_waddr,
	input  logic [cpu_pkg::XLEN-1:0]       i_ex_wdata,
	input  logic                           i_mem_we,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_mem_waddr,
	input  logic [cpu_pkg::XLEN-1:0]       i_mem_wdata,
	output logic                           o_re1,
	output logic                           o_re2,
	output logic [cpu_pkg::REG_ADDR_W-1:0] o_raddr1,
	output logic [cpu_pkg::REG_ADDR_W-1:0] o_raddr2,
	output cpu_pkg::alu_op_e               o_aluop,
	output cpu_pkg::alu_sel_e              o_alusel,
	output logic [cpu_pkg::XLEN-1:0]       o_opv1,
	output logic [cpu_pkg::XLEN-1:0]       o_opv2,
	output logic [cpu_pkg::REG_ADDR_W-1:0] o_waddr,
	output logic                           o_we
);

	cpu_pkg::opcode_e               opcode;
	logic [2:0]                     funct3;
	logic [6:0]                     funct7;
	logic [cpu_pkg::REG_ADDR_W-1:0] rd;
	logic [cpu_pkg::REG_ADDR_W-1:0] rs1;
	logic [cpu_pkg::REG_ADDR_W-1:0] rs2;
	logic [cpu_pkg::XLEN-1:0]       imm_logic;
	logic [cpu_pkg::XLEN-1:0]       imm_shamt;
	logic [cpu_pkg::XLEN-1:0]       imm;
	logic                           inst_valid;

	assign opcode = cpu_pkg::opcode_e'(i_inst[6:0]);
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];
	assign rd     = i_inst[11:7];
	assign rs1    = i_inst[19:15];
	assign rs2    = i_inst[24:20];

	// Zero-extended, unlike the ISA.
	assign imm_logic = {20'h0, i_inst[31:20]};
	assign imm_shamt = {27'h0, i_inst[24:20]};

	always_comb begin
		o_aluop    = cpu_pkg::ALU_NOP;
		o_alusel   = cpu_pkg::SEL_NOP;
		inst_valid = 1'b0;
		imm        = '0;
		o_re1      = 1'b0;
		o_re2      = 1'b0;
		case (opcode)
			cpu_pkg::OPC_OP_IMM: begin
				case (funct3)
					cpu_pkg::FUNCT3_XOR: begin
						o_aluop    = cpu_pkg::ALU_XOR;
						o_alusel   = cpu_pkg::SEL_LOGIC;
						inst_valid = 1'b1;
						imm        = imm_logic;
					end
					cpu_pkg::FUNCT3_OR: begin
						o_aluop    = cpu_pkg::ALU_OR;
						o_alusel   = cpu_pkg::SEL_LOGIC;
						inst_valid = 1'b1;
						imm        = imm_logic;
					end
					cpu_pkg::FUNCT3_AND: begin
						o_aluop    = cpu_pkg::ALU_AND;
						o_alusel   = cpu_pkg::SEL_LOGIC;
						inst_valid = 1'b1;
						imm        = imm_logic;
					end
					cpu_pkg::FUNCT3_SLL: begin
						o_aluop    = cpu_pkg::ALU_SLL;
						o_alusel   = cpu_pkg::SEL_SHIFT;
						inst_valid = 1'b1;
						imm        = imm_shamt;
					end
					cpu_pkg::FUNCT3_SRL_SRA: begin
						// funct7 splits logical from arithmetic.
						if (funct7 == cpu_pkg::FUNCT7_SRL) begin
							o_aluop    = cpu_pkg::ALU_SRL;
							o_alusel   = cpu_pkg::SEL_SHIFT;
							inst_valid = 1'b1;
							imm        = imm_shamt;
						end else if (funct7 == cpu_pkg::FUNCT7_SRA) begin
							o_aluop    = cpu_pkg::ALU_SRA;
							o_alusel   = cpu_pkg::SEL_SHIFT;
							inst_valid = 1'b1;
							imm        = imm_shamt;
						end
					end
					default: begin
					end
				endcase
				o_re1 = inst_valid;
			end
			cpu_pkg::OPC_OP: begin
				case (funct3)
					cpu_pkg::FUNCT3_XOR: begin
						o_aluop    = cpu_pkg::ALU_XOR;
						inst_valid = 1'b1;
					end
					cpu_pkg::FUNCT3_OR: begin
						o_aluop    = cpu_pkg::ALU_OR;
						inst_valid = 1'b1;
					end
					cpu_pkg::FUNCT3_AND: begin
						o_aluop    = cpu_pkg::ALU_AND;
						inst_valid = 1'b1;
					end
					default: begin
					end
				endcase
				if (inst_valid) begin
					o_alusel = cpu_pkg::SEL_LOGIC;
				end
				o_re1 = inst_valid;
				o_re2 = inst_valid;
			end
			default: begin
			end
		endcase
	end

	assign o_raddr1 = rs1;
	assign o_raddr2 = rs2;
	assign o_waddr  = rd;
	assign o_we     = inst_valid && (rd != '0); // No write to x0.

	// Youngest producer wins, then the register file.
	function automatic logic [cpu_pkg::XLEN-1:0] pick_operand(
		input logic                           re,
		input logic [cpu_pkg::REG_ADDR_W-1:0] addr,
		input logic [cpu_pkg::XLEN-1:0]       rdata
	);
		logic [cpu_pkg::XLEN-1:0] val;
		if (!re) begin
			val = imm;
		end else if (i_ex_we && (i_ex_waddr == addr)) begin
			val = i_ex_wdata;
		end else if (i_mem_we && (i_mem_waddr == addr)) begin
			val = i_mem_wdata;
		end else begin
			val = rdata;
		end
		return val;
	endfunction

	always_comb begin
		o_opv1 = pick_operand(o_re1, rs1, i_rdata1);
		o_opv2 = pick_operand(o_re2, rs2, i_rdata2);
	end

endmodule
